// ==== rtl/fb_cfg_pkg.sv ====
//**********************************************************************
// frame buffer configuration package
// widths, the pixel/address/length types, the register map and the
// configuration struct handed from the APB registers to the arbiter
//**********************************************************************
package fb_cfg_pkg;

    localparam int ADDR_W = 12;   // word address, msb is the page bit
    localparam int DATA_W = 16;
    localparam int LEN_W  = 6;
    localparam int CNT_W  = 7;    // holds 0..64

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [DATA_W-1:0] pix_t;
    typedef logic [CNT_W-1:0]  cnt_t;

    typedef struct packed {
        addr_t wr_min;
        addr_t wr_max;
        addr_t rd_min;
        addr_t rd_max;
        len_t  wr_len;
        len_t  rd_len;
        logic  enable;
        logic  pingpong;
    } fb_cfg_t;

    // apb byte offsets
    typedef enum logic [7:0] {
        CTRL   = 8'h00,
        WR_MIN = 8'h04,
        WR_MAX = 8'h08,
        RD_MIN = 8'h0C,
        RD_MAX = 8'h10,
        LEN    = 8'h14,   // wr len in 5..0, rd len in 13..8
        STATUS = 8'h18    // read only
    } reg_addr_e;

endpackage

// ==== rtl/fb_mem_pkg.sv ====
//**********************************************************************
// burst memory package
// arbiter state encoding and the direction of a burst command
//**********************************************************************
package fb_mem_pkg;

    typedef enum logic [1:0] {
        IDLE,    // waiting for the enable bit
        READY,   // free to pick the next burst
        WRITE,
        READ
    } arb_state_e;

    typedef enum logic {
        DIR_WR,  // write fifo -> ram
        DIR_RD   // ram -> read fifo
    } burst_dir_e;

endpackage

// ==== rtl/fb_burst_if.sv ====
//**********************************************************************
// burst command interface between arbiter and burst memory
// req/dir/addr/len held by the arbiter until the one-cycle finish
//**********************************************************************
`timescale 1ns/1ps

interface fb_burst_if;

    logic                   req;
    fb_mem_pkg::burst_dir_e dir;
    fb_cfg_pkg::addr_t      addr;
    fb_cfg_pkg::len_t       len;
    logic                   finish;   // one cycle after the last word

    modport arb (
        output req, dir, addr, len,
        input  finish
    );

    modport mem (
        input  req, dir, addr, len,
        output finish
    );

endinterface

// ==== rtl/fb_apb_regs.sv ====
//**********************************************************************
// APB slave for the frame buffer
// holds address windows, burst lengths, enable and ping-pong bits,
// returns page and frame-count status, no wait states
//**********************************************************************
`timescale 1ns/1ps

module fb_apb_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [7:0]          paddr,
    input  logic [31:0]         pwdata,
    output logic [31:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    output fb_cfg_pkg::fb_cfg_t cfg,
    input  logic                wr_page,
    input  logic                rd_page,
    input  logic [7:0]          wr_frames,
    input  logic [7:0]          rd_frames
);

    localparam int AW = fb_cfg_pkg::ADDR_W;
    localparam int LW = fb_cfg_pkg::LEN_W;

    logic known;       // offset decodes
    logic access;      // access phase
    logic wr_en;

    assign pready  = 1'b1;
    assign access  = psel && penable;
    assign pslverr = access && (!known || (pwrite && paddr == fb_cfg_pkg::STATUS));
    assign wr_en   = access && pwrite && !pslverr;

    // read mux, valid during the access phase
    always_comb begin
        prdata = '0;
        known  = 1'b1;
        case (paddr)
            fb_cfg_pkg::CTRL:   prdata = {30'd0, cfg.pingpong, cfg.enable};
            fb_cfg_pkg::WR_MIN: prdata = {{(32-AW){1'b0}}, cfg.wr_min};
            fb_cfg_pkg::WR_MAX: prdata = {{(32-AW){1'b0}}, cfg.wr_max};
            fb_cfg_pkg::RD_MIN: prdata = {{(32-AW){1'b0}}, cfg.rd_min};
            fb_cfg_pkg::RD_MAX: prdata = {{(32-AW){1'b0}}, cfg.rd_max};
            fb_cfg_pkg::LEN: begin
                prdata[LW-1:0]  = cfg.wr_len;
                prdata[8 +: LW] = cfg.rd_len;
            end
            fb_cfg_pkg::STATUS: prdata = {8'd0, rd_frames, wr_frames, 6'd0, rd_page, wr_page};
            default:            known  = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (wr_en) begin
            case (paddr)
                fb_cfg_pkg::CTRL: begin
                    cfg.enable   <= pwdata[0];
                    cfg.pingpong <= pwdata[1];
                end
                fb_cfg_pkg::WR_MIN: cfg.wr_min <= pwdata[AW-1:0];
                fb_cfg_pkg::WR_MAX: cfg.wr_max <= pwdata[AW-1:0];
                fb_cfg_pkg::RD_MIN: cfg.rd_min <= pwdata[AW-1:0];
                fb_cfg_pkg::RD_MAX: cfg.rd_max <= pwdata[AW-1:0];
                fb_cfg_pkg::LEN: begin
                    cfg.wr_len <= pwdata[LW-1:0];
                    cfg.rd_len <= pwdata[8 +: LW];
                end
                default: cfg <= cfg;
            endcase
        end
    end

    // setup phase must come first
    a_penable_psel: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(penable) |-> psel)
        else $error("penable rose without psel");

endmodule

// ==== rtl/fb_sync_fifo.sv ====
//**********************************************************************
// single clock pixel FIFO with fill count and show-ahead output
// instantiated on the write side and on the read side of the buffer
//**********************************************************************
`timescale 1ns/1ps

module fb_sync_fifo #(
    parameter int FIFO_DEPTH = 64   // power of two
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  fb_cfg_pkg::pix_t wdata,
    input  logic             pop,
    output fb_cfg_pkg::pix_t rdata,
    output logic             full,
    output logic             empty,
    output fb_cfg_pkg::cnt_t count
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    fb_cfg_pkg::pix_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    assign full  = (count == fb_cfg_pkg::cnt_t'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign rdata = mem[rd_ptr];   // head word always visible

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wdata;
    end

    // pointers wrap naturally
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) full |-> !push)
        else $error("push into full fifo");
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) empty |-> !pop)
        else $error("pop from empty fifo");

endmodule

// ==== rtl/fb_burst_arbiter.sv ====
//**********************************************************************
// burst arbiter
// issues write bursts when the write FIFO holds one, read bursts when
// the read FIFO has room, wraps both windows and flips ping-pong pages
//**********************************************************************
`timescale 1ns/1ps

module fb_burst_arbiter #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  fb_cfg_pkg::fb_cfg_t cfg,
    input  logic                wr_load,
    input  logic                rd_load,
    input  fb_cfg_pkg::cnt_t    wfifo_count,
    input  fb_cfg_pkg::cnt_t    rfifo_count,
    fb_burst_if.arb             bus,
    output logic                wr_page,
    output logic                rd_page,
    output logic [7:0]          wr_frames,
    output logic [7:0]          rd_frames
);

    localparam int AW = fb_cfg_pkg::ADDR_W;

    fb_mem_pkg::arb_state_e state;
    logic wr_load_q, rd_load_q;
    logic wr_rise, rd_rise;
    logic wr_pend, rd_pend;      // frame start seen, not yet applied
    logic rd_armed;              // no reads before the first read frame start
    logic wr_take, rd_take;
    logic pp_q;
    fb_cfg_pkg::addr_t wr_cnt, rd_cnt;
    fb_cfg_pkg::addr_t wr_min_q, wr_max_q, rd_min_q, rd_max_q;
    fb_cfg_pkg::len_t  wr_len_q, rd_len_q;
    fb_cfg_pkg::cnt_t  rf_room;
    fb_cfg_pkg::addr_t wr_addr_pg, rd_addr_pg;

    assign wr_rise = wr_load && !wr_load_q;
    assign rd_rise = rd_load && !rd_load_q;
    assign rf_room = fb_cfg_pkg::cnt_t'(FIFO_DEPTH) - rfifo_count;

    // page replaces the address msb in ping-pong mode
    assign wr_addr_pg = pp_q ? {wr_page, wr_cnt[AW-2:0]} : wr_cnt;
    assign rd_addr_pg = pp_q ? {rd_page, rd_cnt[AW-2:0]} : rd_cnt;

    // config is taken on leaving IDLE and when a frame start is applied
    assign wr_take = cfg.enable && (state == fb_mem_pkg::IDLE ||
                     (state == fb_mem_pkg::READY && wr_pend));
    assign rd_take = cfg.enable && (state == fb_mem_pkg::IDLE ||
                     (state == fb_mem_pkg::READY && !wr_pend && rd_pend));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_load_q <= 1'b0;
            rd_load_q <= 1'b0;
            wr_min_q  <= '0;
            wr_max_q  <= '0;
            wr_len_q  <= '0;
            rd_min_q  <= '0;
            rd_max_q  <= '0;
            rd_len_q  <= '0;
            pp_q      <= 1'b0;
        end else begin
            wr_load_q <= wr_load;
            rd_load_q <= rd_load;
            if (wr_take) begin
                wr_min_q <= cfg.wr_min;
                wr_max_q <= cfg.wr_max;
                wr_len_q <= cfg.wr_len;
                pp_q     <= cfg.pingpong;
            end
            if (rd_take) begin
                rd_min_q <= cfg.rd_min;
                rd_max_q <= cfg.rd_max;
                rd_len_q <= cfg.rd_len;
            end
        end
    end

    //******************************************************************
    // burst FSM
    //******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= fb_mem_pkg::IDLE;
            bus.req   <= 1'b0;
            bus.dir   <= fb_mem_pkg::DIR_WR;
            bus.addr  <= '0;
            bus.len   <= '0;
            wr_cnt    <= '0;
            rd_cnt    <= '0;
            wr_pend   <= 1'b0;
            rd_pend   <= 1'b0;
            rd_armed  <= 1'b0;
            wr_page   <= 1'b0;
            rd_page   <= 1'b0;
            wr_frames <= '0;
            rd_frames <= '0;
        end else begin
            case (state)
                fb_mem_pkg::IDLE: begin
                    if (cfg.enable)
                        state <= fb_mem_pkg::READY;
                end
                fb_mem_pkg::READY: begin
                    if (!cfg.enable) begin
                        state <= fb_mem_pkg::IDLE;
                    end else if (wr_pend) begin
                        wr_pend <= 1'b0;                // write restart holds this slot
                    end else if (rd_pend) begin
                        rd_pend  <= 1'b0;
                        rd_armed <= 1'b1;
                    end else if (rd_armed && rd_cnt >= rd_max_q) begin
                        rd_cnt    <= rd_min_q;          // read frame end
                        rd_page   <= ~wr_page;
                        rd_frames <= rd_frames + 1'b1;
                    end else if (wr_cnt >= wr_max_q) begin
                        wr_cnt    <= wr_min_q;          // write frame end
                        wr_page   <= ~wr_page;
                        wr_frames <= wr_frames + 1'b1;
                    end else if (wr_len_q != '0 && wfifo_count >= fb_cfg_pkg::cnt_t'(wr_len_q)) begin
                        state    <= fb_mem_pkg::WRITE;
                        bus.req  <= 1'b1;
                        bus.dir  <= fb_mem_pkg::DIR_WR;
                        bus.addr <= wr_addr_pg;
                        bus.len  <= wr_len_q;
                    end else if (rd_armed && rd_len_q != '0 &&
                                 rf_room >= fb_cfg_pkg::cnt_t'(rd_len_q)) begin
                        state    <= fb_mem_pkg::READ;
                        bus.req  <= 1'b1;
                        bus.dir  <= fb_mem_pkg::DIR_RD;
                        bus.addr <= rd_addr_pg;
                        bus.len  <= rd_len_q;
                    end
                end
                fb_mem_pkg::WRITE: begin
                    if (bus.finish) begin
                        state   <= fb_mem_pkg::READY;
                        bus.req <= 1'b0;
                        wr_cnt  <= wr_cnt + fb_cfg_pkg::addr_t'(bus.len);
                    end
                end
                fb_mem_pkg::READ: begin
                    if (bus.finish) begin
                        state   <= fb_mem_pkg::READY;
                        bus.req <= 1'b0;
                        rd_cnt  <= rd_cnt + fb_cfg_pkg::addr_t'(bus.len);
                    end
                end
                default: state <= fb_mem_pkg::IDLE;
            endcase
            if (wr_take)
                wr_cnt <= cfg.wr_min;
            if (rd_take)
                rd_cnt <= cfg.rd_min;
            if (wr_rise)
                wr_pend <= 1'b1;   // a new edge wins over the clear above
            if (rd_rise)
                rd_pend <= 1'b1;
        end
    end

    // memory relies on a fixed start address for the whole burst
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus.req && $past(bus.req) |-> $stable(bus.addr))
        else $error("burst address changed while req held");

endmodule

// ==== rtl/fb_burst_mem.sv ====
//**********************************************************************
// burst engine over a single-port RAM
// a write burst drains the write FIFO into RAM, a read burst fills the
// read FIFO from RAM, one word per cycle, then a one-cycle finish
//**********************************************************************
`timescale 1ns/1ps

module fb_burst_mem #(
    parameter int MEM_WORDS = 4096
) (
    input  logic             clk,
    input  logic             rst_n,
    fb_burst_if.mem          bus,
    output logic             wf_pop,
    input  fb_cfg_pkg::pix_t wf_data,
    output logic             rf_push,
    output fb_cfg_pkg::pix_t rf_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    fb_cfg_pkg::pix_t ram [MEM_WORDS];
    logic             busy;      // moving words
    fb_cfg_pkg::len_t remain;    // words still to move
    logic [IDX_W-1:0] ptr;

    // dir is held by the arbiter for the whole burst
    assign wf_pop  = busy && (bus.dir == fb_mem_pkg::DIR_WR);
    assign rf_push = busy && (bus.dir == fb_mem_pkg::DIR_RD);
    assign rf_data = ram[ptr];

    always_ff @(posedge clk) begin
        if (wf_pop)
            ram[ptr] <= wf_data;
    end

    //******************************************************************
    // burst sequencing
    //******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            remain     <= '0;
            ptr        <= '0;
            bus.finish <= 1'b0;
        end else begin
            bus.finish <= 1'b0;
            if (busy) begin
                ptr    <= ptr + 1'b1;
                remain <= remain - 1'b1;
                if (remain == fb_cfg_pkg::len_t'(1)) begin
                    busy       <= 1'b0;   // last word this cycle
                    bus.finish <= 1'b1;
                end
            end else if (bus.req && !bus.finish) begin
                // req is still high during finish, so skip that cycle
                ptr        <= bus.addr[IDX_W-1:0];
                remain     <= bus.len;
                busy       <= (bus.len != '0);
                bus.finish <= (bus.len == '0);
            end
        end
    end

    a_finish_in_req: assert property (@(posedge clk) disable iff (!rst_n)
        bus.finish |-> bus.req)
        else $error("finish without a pending request");

endmodule

// ==== rtl/fb_top.sv ====
//**********************************************************************
// two-page frame buffer top level
// pixel stream in -> write FIFO -> burst RAM -> read FIFO -> stream out,
// configured and monitored over APB
//**********************************************************************
`timescale 1ns/1ps

module fb_top #(
    parameter int FIFO_DEPTH = 64,
    parameter int MEM_WORDS  = 4096
) (
    input  logic             clk,
    input  logic             rst_n,
    // apb
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [7:0]       paddr,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    // pixel streams
    input  logic             in_valid,
    input  fb_cfg_pkg::pix_t in_data,
    output logic             in_ready,
    output logic             out_valid,
    output fb_cfg_pkg::pix_t out_data,
    input  logic             out_ready,
    // frame starts
    input  logic             wr_load,
    input  logic             rd_load
);

    fb_cfg_pkg::fb_cfg_t cfg;
    logic                wr_page, rd_page;
    logic [7:0]          wr_frames, rd_frames;
    logic                wf_full, rf_empty;
    logic                wf_pop, rf_push;
    fb_cfg_pkg::pix_t    wf_data, rf_data;
    fb_cfg_pkg::cnt_t    wf_count, rf_count;

    fb_burst_if bus ();

    assign in_ready  = !wf_full;
    assign out_valid = !rf_empty;

    fb_apb_regs u_regs (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .cfg,
        .wr_page, .rd_page, .wr_frames, .rd_frames
    );

    fb_sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_wfifo (
        .clk, .rst_n,
        .push  (in_valid && in_ready),
        .wdata (in_data),
        .pop   (wf_pop),
        .rdata (wf_data),
        .full  (wf_full),
        .empty (),
        .count (wf_count)
    );

    fb_sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rfifo (
        .clk, .rst_n,
        .push  (rf_push),
        .wdata (rf_data),
        .pop   (out_valid && out_ready),
        .rdata (out_data),
        .full  (),
        .empty (rf_empty),
        .count (rf_count)
    );

    fb_burst_arbiter #(.FIFO_DEPTH(FIFO_DEPTH)) u_arb (
        .clk, .rst_n, .cfg, .wr_load, .rd_load,
        .wfifo_count (wf_count),
        .rfifo_count (rf_count),
        .bus         (bus.arb),
        .wr_page, .rd_page, .wr_frames, .rd_frames
    );

    fb_burst_mem #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk, .rst_n,
        .bus     (bus.mem),
        .wf_pop, .wf_data, .rf_push, .rf_data
    );

endmodule

// ==== sim/fb_tb.sv ====
//**********************************************************************
// testbench for the two-page frame buffer
// reads sim/fb_cases.txt, drives APB, the pixel streams and the frame
// pulses, and checks register values and output pixel order
//**********************************************************************
`timescale 1ns/1ps

module fb_tb;

    localparam int MAX_REC = 128;

    logic             clk;
    logic             rst_n;
    logic             psel, penable, pwrite;
    logic [7:0]       paddr;
    logic [31:0]      pwdata, prdata;
    logic             pready, pslverr;
    logic             in_valid, in_ready;
    fb_cfg_pkg::pix_t in_data, out_data;
    logic             out_valid, out_ready;
    logic             wr_load, rd_load;

    logic [7:0]  rec_kind [MAX_REC];
    logic [31:0] rec_a [MAX_REC];
    logic [31:0] rec_b [MAX_REC];
    logic [31:0] rec_c [MAX_REC];
    logic [31:0] rec_d [MAX_REC];
    int          num_rec;
    int          limit_cycles;
    logic        limit_ready;
    integer      seed;

    fb_top #(.FIFO_DEPTH(64), .MEM_WORDS(4096)) DUT (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .in_valid, .in_data, .in_ready,
        .out_valid, .out_data, .out_ready,
        .wr_load, .rd_load
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] got, input logic [31:0] mask);
        if ((got & mask) !== (exp & mask)) begin
            $display("[FAIL] %s expected=%h got=%h", name, exp & mask, got & mask);
            report_failure();
        end
    endtask

    task automatic check_pix(input string name, input fb_cfg_pkg::pix_t exp,
                             input fb_cfg_pkg::pix_t got);
        if (got !== exp) begin
            $display("[FAIL] %s expected=%h got=%h", name, exp, got);
            report_failure();
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("[FAIL] %s expected=%h got=%h", name, exp, got);
            report_failure();
        end
    endtask

    // setup phase, access phase, sample in the middle of access
    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        check_err("pready", 1'b1, pready);   // no wait states
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic push_frame(input int n, input logic [31:0] start);
        int          i;
        logic        acc;
        logic [31:0] status;
        logic        err;
        logic [7:0]  frames;
        apb_access(1'b0, fb_cfg_pkg::STATUS, '0, status, err);
        frames = status[15:8];
        i = 0;
        @(posedge clk);
        in_valid <= 1'b1;
        in_data  <= fb_cfg_pkg::pix_t'(start);
        while (i < n) begin
            @(negedge clk);
            acc = in_ready;
            @(posedge clk);
            if (acc) begin
                i = i + 1;
                if (i < n)
                    in_data <= fb_cfg_pkg::pix_t'(start + i);
                else
                    in_valid <= 1'b0;
            end
        end
        // frame is stored once the write window wraps
        apb_access(1'b0, fb_cfg_pkg::STATUS, '0, status, err);
        while (status[15:8] == frames)
            apb_access(1'b0, fb_cfg_pkg::STATUS, '0, status, err);
    endtask

    task automatic collect_frame(input int n, input logic [31:0] start, input logic stall);
        int          i;
        logic [31:0] rnd;
        i = 0;
        while (i < n) begin
            @(posedge clk);
            if (stall) begin
                rnd = $random(seed);
                out_ready <= rnd[0];
            end else begin
                out_ready <= 1'b1;
            end
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_pix("out_data", fb_cfg_pkg::pix_t'(start + i), out_data);
                i = i + 1;
            end
        end
        @(posedge clk);
        out_ready <= 1'b0;
    endtask

    task automatic load_pulse(input logic side);
        @(posedge clk);
        if (side)
            rd_load <= 1'b1;
        else
            wr_load <= 1'b1;
        @(posedge clk);
        rd_load <= 1'b0;
        wr_load <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic read_cases();
        int           fd;
        int           rc;
        logic [7:0]   tag;
        logic [2047:0] line;
        logic [31:0]  a, b, c, d;
        int           pixels;
        num_rec = 0;
        pixels  = 0;
        fd = $fopen("sim/fb_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file");
            report_failure();
        end
        while (!$feof(fd)) begin
            tag = 8'h00;
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            rc = $fscanf(fd, " %s", tag);
            if (rc == 1) begin
                case (tag)
                    "#": rc = $fgets(line, fd);
                    "W", "O": rc = $fscanf(fd, "%h %h %h", a, b, c);
                    "R": rc = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                    "P": rc = $fscanf(fd, "%h %h", a, b);
                    "L": rc = $fscanf(fd, "%h", a);
                    default: begin
                        $display("unknown record type in the cases file");
                        report_failure();
                    end
                endcase
                if (tag == "P" || tag == "O")
                    pixels = pixels + int'(a);
                if (tag != "#") begin
                    rec_kind[num_rec] = tag;
                    rec_a[num_rec] = a;
                    rec_b[num_rec] = b;
                    rec_c[num_rec] = c;
                    rec_d[num_rec] = d;
                    num_rec = num_rec + 1;
                end
            end
        end
        $fclose(fd);
        limit_cycles = pixels * 40 + 2000;
    endtask

    //******************************************************************
    // watchdog
    //******************************************************************
    initial begin
        wait (limit_ready);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the DUT did not finish the cases in time");
        report_failure();
    end

    initial begin
        logic [31:0] rdata;
        logic        err;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        in_valid    = 1'b0;
        in_data     = '0;
        out_ready   = 1'b0;
        wr_load     = 1'b0;
        rd_load     = 1'b0;
        limit_ready = 1'b0;
        seed        = 32'h937f28a8;
        read_cases();
        limit_ready = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_err("in_ready", 1'b1, in_ready);     // empty write fifo
        check_err("out_valid", 1'b0, out_valid);   // empty read fifo
        for (int r = 0; r < num_rec; r++) begin
            case (rec_kind[r])
                "W": begin
                    apb_access(1'b1, rec_a[r][7:0], rec_b[r], rdata, err);
                    check_err("pslverr", rec_c[r][0], err);
                end
                "R": begin
                    apb_access(1'b0, rec_a[r][7:0], '0, rdata, err);
                    check_err("pslverr", rec_d[r][0], err);
                    check_word("prdata", rec_b[r], rdata, rec_c[r]);
                end
                "P": push_frame(int'(rec_a[r]), rec_b[r]);
                "O": collect_frame(int'(rec_a[r]), rec_b[r], rec_c[r][0]);
                default: load_pulse(rec_a[r][0]);
            endcase
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== sim/fb_cases.txt ====
# all fields hex: W offset data err | R offset expected mask err
# P count start | O count start stall | L side (0 write, 1 read)
# register readback masked to field widths
W 04 fffff123 0
R 04 00000123 ffffffff 0
W 08 0000abcd 0
R 08 00000bcd ffffffff 0
W 0c 12345678 0
R 0c 00000678 ffffffff 0
W 10 ffffffff 0
R 10 00000fff ffffffff 0
W 14 ffffffff 0
R 14 00003f3f ffffffff 0
W 00 fffffffe 0
R 00 00000002 ffffffff 0
# unknown offsets and a write to status
W 1c 00000001 1
R 20 00000000 00000000 1
W 18 ffffffff 1
R 18 00000000 ffffffff 0
# ping-pong off, both windows 0..256, bursts of 16
W 04 00000000 0
W 08 00000100 0
W 0c 00000000 0
W 10 00000100 0
W 14 00001010 0
W 00 00000001 0
P 100 1000
R 18 00000101 0000ff01 0
L 1
O 100 1000 0
# same frame again with random output stalls
O 100 1000 1
# ping-pong on, two more write frames
W 00 00000003 0
L 0
P 100 2000
R 18 00000200 0000ff01 0
P 100 3000
R 18 00000301 0000ff01 0
R 00 00000003 ffffffff 0
# read restart, buffered pixels first, then the last written frame
L 1
O 40 1000 0
O 100 3000 0

// ==== fb_frame_buf.f ====
rtl/fb_cfg_pkg.sv
rtl/fb_mem_pkg.sv
rtl/fb_burst_if.sv
rtl/fb_apb_regs.sv
rtl/fb_sync_fifo.sv
rtl/fb_burst_arbiter.sv
rtl/fb_burst_mem.sv
rtl/fb_top.sv
sim/fb_tb.sv
